// ==== Bender.yml ====
package:
  name: sw_tx_mux

sources:
  - files:
      - hdl/gmii_pkg.sv
      - hdl/tx_mux_pkg.sv
      - hdl/gmii_delay_line.sv
      - hdl/port_fifo.sv
      - hdl/tx_scheduler.sv
      - hdl/tx_output_stage.sv
      - hdl/sw_tx_mux.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_sw_tx_mux.sv

// ==== filelist.f ====
+incdir+verification
hdl/gmii_pkg.sv
hdl/tx_mux_pkg.sv
hdl/gmii_delay_line.sv
hdl/port_fifo.sv
hdl/tx_scheduler.sv
hdl/tx_output_stage.sv
hdl/sw_tx_mux.sv
verification/tb_sw_tx_mux.sv

// ==== hdl/gmii_delay_line.sv ====
// Fixed-depth shift register delay for one GMII stream
`timescale 1ns/1ns

module gmii_delay_line #(
  parameter int P0_DELAY = tx_mux_pkg::DEF_P0_DELAY
)
(
  input  logic                I_125m_clk,
  input  logic                in_dv,
  input  gmii_pkg::gmii_byte_t in_d,
  output logic                out_dv,
  output gmii_pkg::gmii_byte_t out_d
);

  // One stage per cycle of delay
  gmii_pkg::gmii_word_t taps [P0_DELAY];

  // ----------------------------------------
  // Shift chain
  // ----------------------------------------
  always_ff @(posedge I_125m_clk)
  begin
    taps[0] <= {in_dv, in_d};
    for (int i = 1; i < P0_DELAY; i++)
    begin
      taps[i] <= taps[i-1];
    end
  end

  // Last stage is exactly P0_DELAY cycles behind the input
  assign out_dv = taps[P0_DELAY-1][8];
  assign out_d  = taps[P0_DELAY-1][7:0];

endmodule

// ==== hdl/gmii_pkg.sv ====
// GMII byte and FIFO word types, input port count

package gmii_pkg;

  // ----------------------------------------
  // Data types
  // ----------------------------------------

  // One byte on the GMII data lines
  typedef logic [7:0] gmii_byte_t;

  // Buffered word with dv on top of the data byte
  typedef logic [8:0] gmii_word_t;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  // Number of transmit inputs into the mux
  localparam int NUM_PORTS = 4;

endpackage

// ==== hdl/port_fifo.sv ====
// Per-port packet FIFO with trailer write stretch, fill count and checks
`timescale 1ns/1ns

module port_fifo #(
  parameter int FIFO_DEPTH  = 4096,
  parameter int TRAIL_WORDS = tx_mux_pkg::DEF_TRAIL_WORDS
)
(
  input  logic                  I_125m_clk,
  input  logic                  I_rst,
  input  logic                  wr_dv,
  input  gmii_pkg::gmii_byte_t  wr_d,
  input  logic                  rd_en,
  output gmii_pkg::gmii_word_t  q,
  output tx_mux_pkg::fill_cnt_t fill
);

  localparam int PTR_W  = $clog2(FIFO_DEPTH);
  localparam int TAIL_W = $clog2(TRAIL_WORDS + 1);

  gmii_pkg::gmii_word_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [TAIL_W-1:0]    tail_cnt;
  logic                 wr_en;
  logic                 full;

  // ----------------------------------------
  // Write side
  // ----------------------------------------

  // Keep writing for TRAIL_WORDS idle words after dv drops
  assign wr_en = wr_dv | (tail_cnt != '0);
  assign full  = (fill == FIFO_DEPTH);

  always_ff @(posedge I_125m_clk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr] <= {wr_dv, wr_d};
    end
  end

  // ----------------------------------------
  // Pointers, tail and fill
  // ----------------------------------------
  always_ff @(posedge I_125m_clk or posedge I_rst)
  begin
    if (I_rst)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      tail_cnt <= '0;
      fill     <= '0;
      q        <= '0;
    end
    else
    begin
      if (wr_dv)
        tail_cnt <= TAIL_W'(TRAIL_WORDS);
      else if (tail_cnt != '0)
        tail_cnt <= tail_cnt - 1'b1;

      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;

      // Head word shows up one cycle after the strobe
      if (rd_en)
      begin
        q      <= mem[rd_ptr];
        rd_ptr <= rd_ptr + 1'b1;
      end

      if (wr_en && !rd_en)
        fill <= fill + 1'b1;
      else if (rd_en && !wr_en)
        fill <= fill - 1'b1;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // There is no back-pressure toward the input port
  a_no_write_full: assert property (@(posedge I_125m_clk) disable iff (I_rst)
    wr_en |-> !full)
    else $error("port_fifo write while full");

  // Scheduler must only read words that were written
  a_no_read_empty: assert property (@(posedge I_125m_clk) disable iff (I_rst)
    rd_en |-> (fill != '0))
    else $error("port_fifo read while empty");

endmodule

// ==== hdl/sw_tx_mux.sv ====
// Top level of the four-port GMII transmit mux
`timescale 1ns/1ns

module sw_tx_mux #(
  parameter int P0_DELAY    = tx_mux_pkg::DEF_P0_DELAY,
  parameter int FIFO_DEPTH  = 4096,
  parameter int TRAIL_WORDS = tx_mux_pkg::DEF_TRAIL_WORDS,
  parameter int START_LEVEL = tx_mux_pkg::DEF_START_LEVEL,
  parameter int GAP_MIN     = tx_mux_pkg::DEF_GAP_MIN
)
(
  input  logic                 I_125m_clk,
  input  logic                 I_rst,
  input  logic                 I_tx_gmii_dv_p0,
  input  logic                 I_tx_gmii_dv_p1,
  input  logic                 I_tx_gmii_dv_p2,
  input  logic                 I_tx_gmii_dv_p3,
  input  gmii_pkg::gmii_byte_t I_tx_gmii_d_p0,
  input  gmii_pkg::gmii_byte_t I_tx_gmii_d_p1,
  input  gmii_pkg::gmii_byte_t I_tx_gmii_d_p2,
  input  gmii_pkg::gmii_byte_t I_tx_gmii_d_p3,
  output logic [3:0]           O_tx_port_info,
  output logic                 O_tx_gmii_dv,
  output gmii_pkg::gmii_byte_t O_tx_gmii_d
);

  logic                           dly_dv;
  gmii_pkg::gmii_byte_t           dly_d;
  logic [gmii_pkg::NUM_PORTS-1:0] rd_en;
  gmii_pkg::gmii_word_t           q_p0, q_p1, q_p2, q_p3;
  tx_mux_pkg::fill_cnt_t          fill_p0, fill_p1, fill_p2, fill_p3;
  logic                           sending;
  tx_mux_pkg::port_idx_t          cur_port;

  // ----------------------------------------
  // Port 0 held back behind returned packets
  // ----------------------------------------
  gmii_delay_line #(.P0_DELAY(P0_DELAY)) u_p0_delay (
    .I_125m_clk (I_125m_clk),
    .in_dv      (I_tx_gmii_dv_p0),
    .in_d       (I_tx_gmii_d_p0),
    .out_dv     (dly_dv),
    .out_d      (dly_d)
  );

  // ----------------------------------------
  // Per-port buffers
  // ----------------------------------------
  port_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .TRAIL_WORDS(TRAIL_WORDS)) u_fifo_p0 (
    .I_125m_clk (I_125m_clk), .I_rst (I_rst),
    .wr_dv (dly_dv), .wr_d (dly_d), .rd_en (rd_en[0]),
    .q (q_p0), .fill (fill_p0)
  );

  port_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .TRAIL_WORDS(TRAIL_WORDS)) u_fifo_p1 (
    .I_125m_clk (I_125m_clk), .I_rst (I_rst),
    .wr_dv (I_tx_gmii_dv_p1), .wr_d (I_tx_gmii_d_p1), .rd_en (rd_en[1]),
    .q (q_p1), .fill (fill_p1)
  );

  port_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .TRAIL_WORDS(TRAIL_WORDS)) u_fifo_p2 (
    .I_125m_clk (I_125m_clk), .I_rst (I_rst),
    .wr_dv (I_tx_gmii_dv_p2), .wr_d (I_tx_gmii_d_p2), .rd_en (rd_en[2]),
    .q (q_p2), .fill (fill_p2)
  );

  port_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .TRAIL_WORDS(TRAIL_WORDS)) u_fifo_p3 (
    .I_125m_clk (I_125m_clk), .I_rst (I_rst),
    .wr_dv (I_tx_gmii_dv_p3), .wr_d (I_tx_gmii_d_p3), .rd_en (rd_en[3]),
    .q (q_p3), .fill (fill_p3)
  );

  // ----------------------------------------
  // Scheduling and output
  // ----------------------------------------
  tx_scheduler #(.START_LEVEL(START_LEVEL), .GAP_MIN(GAP_MIN)) u_sched (
    .I_125m_clk (I_125m_clk), .I_rst (I_rst),
    .fill_p0 (fill_p0), .fill_p1 (fill_p1), .fill_p2 (fill_p2), .fill_p3 (fill_p3),
    .head_dv ({q_p3[8], q_p2[8], q_p1[8], q_p0[8]}),
    .rd_en (rd_en), .sending (sending), .cur_port (cur_port)
  );

  tx_output_stage u_out (
    .I_125m_clk (I_125m_clk), .I_rst (I_rst),
    .sending (sending), .cur_port (cur_port),
    .q_p0 (q_p0), .q_p1 (q_p1), .q_p2 (q_p2), .q_p3 (q_p3),
    .tx_dv (O_tx_gmii_dv), .tx_d (O_tx_gmii_d), .port_info (O_tx_port_info)
  );

endmodule

// ==== hdl/tx_mux_pkg.sv ====
// Scheduler state enum, port index and fill types, default thresholds

package tx_mux_pkg;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  // Index of one input port
  typedef logic [1:0] port_idx_t;

  // FIFO fill level with one bit above the address for a full 4096 FIFO
  typedef logic [12:0] fill_cnt_t;

  // Scheduler states
  typedef enum logic [1:0] {
    IDLE,
    GAP,
    SEND
  } sched_state_t;

  // ----------------------------------------
  // Defaults
  // ----------------------------------------

  localparam int DEF_START_LEVEL = 8;
  localparam int DEF_GAP_MIN     = 8;
  localparam int DEF_TRAIL_WORDS = 2;
  // Long enough for a returned port 1 packet to get ahead
  localparam int DEF_P0_DELAY    = 32;

endpackage

// ==== hdl/tx_output_stage.sv ====
// Output data register and port-info register of the transmit mux
`timescale 1ns/1ns

module tx_output_stage
(
  input  logic                  I_125m_clk,
  input  logic                  I_rst,
  input  logic                  sending,
  input  tx_mux_pkg::port_idx_t cur_port,
  input  gmii_pkg::gmii_word_t  q_p0,
  input  gmii_pkg::gmii_word_t  q_p1,
  input  gmii_pkg::gmii_word_t  q_p2,
  input  gmii_pkg::gmii_word_t  q_p3,
  output logic                  tx_dv,
  output gmii_pkg::gmii_byte_t  tx_d,
  output logic [3:0]            port_info
);

  gmii_pkg::gmii_word_t head;
  logic                 tx_dv_d;

  // Head word of the port being served
  always_comb
  begin
    case (cur_port)
      2'd0:    head = q_p0;
      2'd1:    head = q_p1;
      2'd2:    head = q_p2;
      default: head = q_p3;
    endcase
  end

  // ----------------------------------------
  // Output registers
  // ----------------------------------------
  always_ff @(posedge I_125m_clk or posedge I_rst)
  begin
    if (I_rst)
    begin
      tx_dv     <= 1'b0;
      tx_d      <= '0;
      tx_dv_d   <= 1'b0;
      port_info <= '0;
    end
    else
    begin
      tx_dv_d <= tx_dv;
      // Idle bus outside of a send
      if (sending)
      begin
        tx_dv <= head[8];
        tx_d  <= head[7:0];
      end
      else
      begin
        tx_dv <= 1'b0;
        tx_d  <= '0;
      end
      // Tag taken at packet start and held until the next one
      if (tx_dv && !tx_dv_d)
        port_info <= {2'b00, cur_port};
    end
  end

endmodule

// ==== hdl/tx_scheduler.sv ====
// Round-robin packet scheduler with gap counter and read enables
`timescale 1ns/1ns

module tx_scheduler #(
  parameter int START_LEVEL = tx_mux_pkg::DEF_START_LEVEL,
  parameter int GAP_MIN     = tx_mux_pkg::DEF_GAP_MIN
)
(
  input  logic                            I_125m_clk,
  input  logic                            I_rst,
  input  tx_mux_pkg::fill_cnt_t           fill_p0,
  input  tx_mux_pkg::fill_cnt_t           fill_p1,
  input  tx_mux_pkg::fill_cnt_t           fill_p2,
  input  tx_mux_pkg::fill_cnt_t           fill_p3,
  input  logic [gmii_pkg::NUM_PORTS-1:0]  head_dv,
  output logic [gmii_pkg::NUM_PORTS-1:0]  rd_en,
  output logic                            sending,
  output tx_mux_pkg::port_idx_t           cur_port
);

  localparam int GAP_W = $clog2(GAP_MIN + 1);

  tx_mux_pkg::sched_state_t         state;
  logic [GAP_W-1:0]                 gap_cnt;
  logic [gmii_pkg::NUM_PORTS-1:0]   rd_en_d;
  logic [gmii_pkg::NUM_PORTS-1:0]   ready;
  logic                             found;
  tx_mux_pkg::port_idx_t            pick;
  tx_mux_pkg::port_idx_t            cand;
  logic                             pkt_end;

  // Ports holding at least the start threshold
  assign ready[0] = (fill_p0 >= START_LEVEL);
  assign ready[1] = (fill_p1 >= START_LEVEL);
  assign ready[2] = (fill_p2 >= START_LEVEL);
  assign ready[3] = (fill_p3 >= START_LEVEL);

  // ----------------------------------------
  // Rotating choice
  // ----------------------------------------

  // Walk down so the nearest ready port from cur_port upward wins
  always_comb
  begin
    found = 1'b0;
    pick  = cur_port;
    cand  = cur_port;
    for (int i = gmii_pkg::NUM_PORTS - 1; i >= 0; i--)
    begin
      cand = cur_port + tx_mux_pkg::port_idx_t'(i);
      if (ready[cand])
      begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  // First trailer word seen at the head of a port being read
  assign pkt_end = rd_en_d[cur_port] && !head_dv[cur_port];
  assign sending = (state == tx_mux_pkg::SEND);

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_ff @(posedge I_125m_clk or posedge I_rst)
  begin
    if (I_rst)
    begin
      state    <= tx_mux_pkg::IDLE;
      cur_port <= '0;
      gap_cnt  <= '0;
    end
    else
    begin
      case (state)
        tx_mux_pkg::IDLE:
        begin
          gap_cnt <= '0;
          if (|ready)
          begin
            state    <= tx_mux_pkg::GAP;
            cur_port <= '0;
          end
        end
        tx_mux_pkg::GAP:
        begin
          if (gap_cnt < GAP_MIN)
            gap_cnt <= gap_cnt + 1'b1;
          else if (found)
          begin
            state    <= tx_mux_pkg::SEND;
            cur_port <= pick;
          end
          else
            cur_port <= cur_port + 1'b1;
        end
        tx_mux_pkg::SEND:
        begin
          gap_cnt <= '0;
          if (pkt_end)
          begin
            state    <= tx_mux_pkg::GAP;
            cur_port <= cur_port + 1'b1;
          end
        end
        default:
          state <= tx_mux_pkg::IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Read strobes
  // ----------------------------------------

  // Dropping on pkt_end leaves exactly two trailer words consumed
  always_ff @(posedge I_125m_clk or posedge I_rst)
  begin
    if (I_rst)
    begin
      rd_en   <= '0;
      rd_en_d <= '0;
    end
    else
    begin
      rd_en_d <= rd_en;
      for (int i = 0; i < gmii_pkg::NUM_PORTS; i++)
      begin
        rd_en[i] <= sending && !pkt_end && (cur_port == tx_mux_pkg::port_idx_t'(i));
      end
    end
  end

  // Only one port in the read pipeline at a time, delayed strobes included
  a_one_reader: assert property (@(posedge I_125m_clk) disable iff (I_rst)
    $onehot0(rd_en | rd_en_d))
    else $error("tx_scheduler more than one FIFO read at once");

endmodule

// ==== verification/tb_sw_tx_mux_ref.svh ====
// Reference rules of the transmit mux for rotating port choice and gap verdict
`ifndef TB_SW_TX_MUX_REF_SVH
`define TB_SW_TX_MUX_REF_SVH

// ----------------------------------------
// Port order
// ----------------------------------------

// First pending port above the last served one with wrap after port 3
function automatic int next_port(input int last, input logic [3:0] pending);
  int p;
  for (int i = 1; i <= 4; i++)
  begin
    p = (last + i) % 4;
    if (pending[p])
      return p;
  end
  // Nothing left to serve
  return -1;
endfunction

// ----------------------------------------
// Gap rule
// ----------------------------------------

// Idle cycles ahead of a packet against the minimum gap
function automatic bit gap_ok(input int idle, input int gap_min);
  return idle >= gap_min;
endfunction

`endif

// ==== verification/tb_sw_tx_mux.sv ====
// Stimulus, monitor, checker and watchdog for the four-port GMII transmit mux
`timescale 1ns/1ns

module tb_sw_tx_mux;

  localparam int P0_DELAY   = tx_mux_pkg::DEF_P0_DELAY;
  localparam int GAP_MIN    = tx_mux_pkg::DEF_GAP_MIN;
  localparam int P1_LEAD    = 4;
  // Reset, three directed tests and 40 random packets at worst-case length
  localparam int RUN_CYCLES = 8 + 20 + 3 * 400 + 40 * (64 + 20 + GAP_MIN + 4);

  logic                 I_125m_clk;
  logic                 I_rst;
  logic [3:0]           dv;
  gmii_pkg::gmii_byte_t d [4];
  logic [3:0]           port_info;
  logic                 tx_dv;
  gmii_pkg::gmii_byte_t tx_d;

  int                   errors = 0;
  int                   sent = 0;
  int                   delivered = 0;
  string                test_name;
  gmii_pkg::gmii_byte_t exp_q [4][$];
  int                   exp_len [4][$];
  gmii_pkg::gmii_byte_t rx_bytes [$];
  int                   rx_len [$];
  int                   rx_gap [$];
  int                   rx_info [$];
  logic [3:0]           order_left;
  logic [3:0]           order_first;
  int                   order_last;
  int                   cur_len = 0;
  int                   idle = 0;
  bit                   seen = 1'b0;

  `include "tb_sw_tx_mux_ref.svh"

  sw_tx_mux #(.P0_DELAY(P0_DELAY), .GAP_MIN(GAP_MIN)) uut (
    .I_125m_clk (I_125m_clk), .I_rst (I_rst),
    .I_tx_gmii_dv_p0 (dv[0]), .I_tx_gmii_dv_p1 (dv[1]),
    .I_tx_gmii_dv_p2 (dv[2]), .I_tx_gmii_dv_p3 (dv[3]),
    .I_tx_gmii_d_p0 (d[0]), .I_tx_gmii_d_p1 (d[1]),
    .I_tx_gmii_d_p2 (d[2]), .I_tx_gmii_d_p3 (d[3]),
    .O_tx_port_info (port_info), .O_tx_gmii_dv (tx_dv), .O_tx_gmii_d (tx_d)
  );

  initial
  begin
    I_125m_clk = 1'b0;
    forever #4 I_125m_clk = ~I_125m_clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic report_mismatch(input string what, input int expected, input int actual);
    errors++;
    $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
  endtask

  // One packet of random bytes recorded for the checker
  task automatic send_packet(input int port, input int len);
    gmii_pkg::gmii_byte_t b;
    exp_len[port].push_back(len);
    sent++;
    for (int i = 0; i < len; i++)
    begin
      b = 8'($urandom);
      exp_q[port].push_back(b);
      @(posedge I_125m_clk);
      #1;
      dv[port] = 1'b1;
      d[port]  = b;
    end
    @(posedge I_125m_clk);
    #1;
    dv[port] = 1'b0;
    d[port]  = '0;
  endtask

  // Idle of at least 3 cycles keeps the trailer words apart
  task automatic run_port(input int port, input int count);
    for (int i = 0; i < count; i++)
    begin
      repeat (3 + $urandom % 18) @(posedge I_125m_clk);
      send_packet(port, 8 + $urandom % 57);
    end
  endtask

  task automatic set_order(input logic [3:0] left, input logic [3:0] first);
    order_left  = left;
    order_first = first;
    order_last  = -1;
  endtask

  task automatic wait_drained();
    wait (delivered == sent);
    repeat (30) @(posedge I_125m_clk);
  endtask

  function automatic bit head_match(input int port, input int n);
    if (exp_len[port].size() == 0 || exp_len[port][0] != n)
      return 1'b0;
    for (int i = 0; i < n; i++)
      if (exp_q[port][i] != rx_bytes[i])
        return 1'b0;
    return 1'b1;
  endfunction

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial
  begin
    void'($urandom(32'h1cb4));
    I_rst = 1'b1;
    dv    = '0;
    for (int k = 0; k < 4; k++)
      d[k] = '0;
    set_order('0, '0);
    test_name = "reset_idle";
    repeat (8) @(posedge I_125m_clk);
    #1;
    I_rst = 1'b0;
    repeat (20) @(posedge I_125m_clk);

    test_name = "single_p2";
    set_order(4'b0100, 4'b0100);
    send_packet(2, 8 + $urandom % 57);
    wait_drained();

    // Port 1 wins when it starts inside the port 0 delay
    test_name = "p1_overtakes_p0";
    set_order(4'b0011, (P1_LEAD < P0_DELAY) ? 4'b0010 : 4'b0001);
    fork
      send_packet(0, 8 + $urandom % 57);
      begin
        repeat (P1_LEAD) @(posedge I_125m_clk);
        send_packet(1, 8 + $urandom % 57);
      end
    join
    wait_drained();

    // Port 0 is still in its delay line at the first choice
    test_name = "all_ports_rotate";
    set_order(4'b1111, 4'b1110);
    fork
      send_packet(0, 40 + $urandom % 25);
      send_packet(1, 40 + $urandom % 25);
      send_packet(2, 40 + $urandom % 25);
      send_packet(3, 40 + $urandom % 25);
    join
    wait_drained();

    test_name = "random_40";
    set_order('0, '0);
    fork
      run_port(0, 10);
      run_port(1, 10);
      run_port(2, 10);
      run_port(3, 10);
    join
    wait_drained();

    $display("Errors: %0d, packets checked: %0d of %0d", errors, delivered, sent);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------
  // Monitor and compare
  // ----------------------------------------

  // Output registers settle after the rising edge
  always @(negedge I_125m_clk)
  begin
    if (!I_rst)
    begin
      if (tx_dv)
      begin
        rx_bytes.push_back(tx_d);
        cur_len++;
      end
      else
      begin
        if (cur_len > 0)
        begin
          rx_len.push_back(cur_len);
          rx_gap.push_back(idle);
          rx_info.push_back(int'(port_info));
          cur_len = 0;
          idle    = 0;
          seen    = 1'b1;
        end
        idle++;
        if (!seen)
          assert (tx_d == '0 && port_info == '0)
          else report_mismatch("idle outputs", 0, int'({tx_d, port_info}));
      end
    end
  end

  initial
  begin
    int n;
    int gap;
    int info;
    int port;
    int exp_port;
    forever
    begin
      wait (rx_len.size() > 0);
      n    = rx_len.pop_front();
      gap  = rx_gap.pop_front();
      info = rx_info.pop_front();
      port = -1;
      // Only the oldest packet of each port may match
      for (int k = 3; k >= 0; k--)
        if (head_match(k, n))
          port = k;
      assert (port >= 0)
      else
      begin
        errors++;
        $display("%s: output packet of %0d bytes matches no pending input packet", test_name, n);
      end
      if (port >= 0)
      begin
        assert (info == port) else report_mismatch("port_info", port, info);
        repeat (n) void'(exp_q[port].pop_front());
        void'(exp_len[port].pop_front());
        if (order_left != '0)
        begin
          // Any port of the first set may open the test
          if (order_last < 0)
          begin
            assert (order_first[port])
            else report_mismatch("first port set", int'(order_first), port);
          end
          else
          begin
            exp_port = next_port(order_last, order_left);
            assert (port == exp_port) else report_mismatch("port order", exp_port, port);
          end
          order_left[port] = 1'b0;
          order_last       = port;
        end
      end
      assert (gap_ok(gap, GAP_MIN)) else report_mismatch("idle gap", GAP_MIN, gap);
      repeat (n) void'(rx_bytes.pop_front());
      delivered++;
    end
  end

  // Watchdog
  initial
  begin
    #((RUN_CYCLES + 2000) * 8);
    $display("Timeout: only %0d of %0d packets left the mux", delivered, sent);
    $display("*** FAILED ***");
    $finish;
  end

endmodule
